/* rtl/switch_pkg.sv */
// Shared widths, tuser byte positions and depth defaults, referenced by scoped name in the RTL
package switch_pkg;

   //////////////////////////////
   // Stream widths
   //////////////////////////////

   // Default tdata width in bits
   localparam int axis_data_width_default = 64;

   // Default tuser width in bits
   localparam int axis_user_width_default = 128;

   //////////////////////////////
   // Port fields in tuser
   //////////////////////////////

   // One-hot source port byte
   localparam int src_port_pos = 16;

   // One-hot destination port byte
   localparam int dst_port_pos = 24;

   // Width of either port field
   localparam int port_byte_w = 8;

   // Ingress streams into the arbiter
   localparam int num_ingress = 2;

   //////////////////////////////
   // Buffering
   //////////////////////////////

   // Log2 of the default FIFO depth
   localparam int fifo_depth_bits_default = 2;

endpackage

/* rtl/small_fifo.sv */
// Synchronous ring-buffer FIFO with registered read data, used by the lookup and the queues
`timescale 1ns/1ps

module small_fifo #(
   parameter int WIDTH          = 72,
   parameter int MAX_DEPTH_BITS = switch_pkg::fifo_depth_bits_default
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [WIDTH-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             nearly_full,
   output logic             empty
);

   localparam int depth = 2 ** MAX_DEPTH_BITS;

   // Storage and pointers
   logic [WIDTH-1:0]          mem [depth];
   logic [MAX_DEPTH_BITS-1:0] wr_ptr;
   logic [MAX_DEPTH_BITS-1:0] rd_ptr;
   logic [MAX_DEPTH_BITS:0]   depth_cnt;
   logic                      do_wr;
   logic                      do_rd;

   // Guard against overflow and underflow
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Flags straight from the count
   assign empty       = (depth_cnt == '0);
   assign full        = (depth_cnt == depth);
   // One free entry left
   assign nearly_full = (depth_cnt >= depth - 1);

   // Array write and registered read
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
      if (do_rd) begin
         dout <= mem[rd_ptr];
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         depth_cnt <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Count moves only when one side acts alone
         if (do_wr && !do_rd) begin
            depth_cnt <= depth_cnt + 1'b1;
         end else if (do_rd && !do_wr) begin
            depth_cnt <= depth_cnt - 1'b1;
         end
      end
   end

endmodule

/* rtl/input_arbiter.sv */
// Packet-granular round-robin merge of the MAC and CPU ingress streams, stamps the source port
`timescale 1ns/1ps

module input_arbiter #(
   parameter int C_AXIS_DATA_WIDTH = 64,
   parameter int C_USER_WIDTH      = 128
) (
   input  logic                           axi_aclk,
   input  logic                           axi_resetn,
   // Ingress 0, physical port
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s0_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s0_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s0_axis_tuser,
   input  logic                           s0_axis_tvalid,
   output logic                           s0_axis_tready,
   input  logic                           s0_axis_tlast,
   // Ingress 1, CPU port
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s1_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s1_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s1_axis_tuser,
   input  logic                           s1_axis_tvalid,
   output logic                           s1_axis_tready,
   input  logic                           s1_axis_tlast,
   // Merged stream
   output logic [C_AXIS_DATA_WIDTH-1:0]   m_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m_axis_tuser,
   output logic                           m_axis_tvalid,
   input  logic                           m_axis_tready,
   output logic                           m_axis_tlast
);

   localparam int src_pos = switch_pkg::src_port_pos;
   localparam int byte_w  = switch_pkg::port_byte_w;

   //////////////////////////////
   // Grant state
   //////////////////////////////

   logic [$clog2(switch_pkg::num_ingress)-1:0] grant;
   logic                                       in_pkt;
   logic                                       cur_valid;
   logic                                       other_valid;
   logic                                       xfer;
   logic [C_USER_WIDTH-1:0]                    sel_tuser;

   // Granted and waiting inputs
   assign cur_valid   = grant ? s1_axis_tvalid : s0_axis_tvalid;
   assign other_valid = grant ? s0_axis_tvalid : s1_axis_tvalid;

   // Ready only to the granted side
   assign s0_axis_tready = m_axis_tready && (grant == 1'b0);
   assign s1_axis_tready = m_axis_tready && (grant == 1'b1);

   //////////////////////////////
   // Combinational forward
   //////////////////////////////

   assign m_axis_tvalid = cur_valid;
   assign m_axis_tdata  = grant ? s1_axis_tdata : s0_axis_tdata;
   assign m_axis_tstrb  = grant ? s1_axis_tstrb : s0_axis_tstrb;
   assign m_axis_tlast  = grant ? s1_axis_tlast : s0_axis_tlast;
   assign sel_tuser     = grant ? s1_axis_tuser : s0_axis_tuser;

   // Input i gets one-hot bit i in the source byte
   always_comb begin
      m_axis_tuser = sel_tuser;
      m_axis_tuser[src_pos +: byte_w] = byte_w'(1) << grant;
   end

   assign xfer = m_axis_tvalid && m_axis_tready;

   // Hold the grant for a whole packet
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         grant  <= '0;
         in_pkt <= 1'b0;
      end else if (xfer && m_axis_tlast) begin
         in_pkt <= 1'b0;
         // Boundary, hand over if the other side waits
         if (other_valid) begin
            grant <= ~grant;
         end
      end else if (xfer) begin
         in_pkt <= 1'b1;
      end else if (!in_pkt && !cur_valid && other_valid) begin
         // Idle granted input
         grant <= ~grant;
      end
   end

endmodule

/* rtl/output_port_lookup.sv */
// Rewrites the destination port byte on each packet header, CPU to MAC and MAC to CPU
`timescale 1ns/1ps

module output_port_lookup #(
   parameter int C_AXIS_DATA_WIDTH = 64,
   parameter int C_USER_WIDTH      = 128,
   parameter int SRC_PORT_POS      = 16,
   parameter int DST_PORT_POS      = 24
) (
   input  logic                           axi_aclk,
   input  logic                           axi_resetn,
   // Toward the output queues
   output logic [C_AXIS_DATA_WIDTH-1:0]   m_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m_axis_tuser,
   output logic                           m_axis_tvalid,
   input  logic                           m_axis_tready,
   output logic                           m_axis_tlast,
   // From the arbiter
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s_axis_tuser,
   input  logic                           s_axis_tvalid,
   output logic                           s_axis_tready,
   input  logic                           s_axis_tlast
);

   localparam int byte_w = switch_pkg::port_byte_w;
   localparam int beat_w = C_AXIS_DATA_WIDTH + C_AXIS_DATA_WIDTH / 8 + C_USER_WIDTH + 1;

   localparam logic st_header    = 1'b0;
   localparam logic st_in_packet = 1'b1;

   logic                    state;
   logic [C_USER_WIDTH-1:0] tuser_mod;
   logic [byte_w-1:0]       src_byte;
   logic [byte_w-1:0]       dst_byte;
   logic                    pkt_from_cpu;
   logic                    xfer;
   logic                    fifo_nearly_full;
   logic                    fifo_empty;
   logic                    fifo_rd_en;

   //////////////////////////////
   // Header rewrite
   //////////////////////////////

   assign src_byte = s_axis_tuser[SRC_PORT_POS +: byte_w];
   // CPU ports sit on the odd bits
   assign pkt_from_cpu = |(src_byte & {(byte_w / 2){2'b10}});
   // Shift result truncated to the byte
   assign dst_byte = pkt_from_cpu ? (src_byte >> 1) : (src_byte << 1);

   always_comb begin
      tuser_mod = s_axis_tuser;
      if (state == st_header) begin
         tuser_mod[DST_PORT_POS +: byte_w] = dst_byte;
      end
   end

   assign xfer = s_axis_tvalid && s_axis_tready;

   // Header versus rest of packet
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= st_header;
      end else if (xfer) begin
         state <= s_axis_tlast ? st_header : st_in_packet;
      end
   end

   //////////////////////////////
   // Buffer and output
   //////////////////////////////

   assign s_axis_tready = !fifo_nearly_full;

   small_fifo #(
      .WIDTH          (beat_w),
      .MAX_DEPTH_BITS (switch_pkg::fifo_depth_bits_default)
   ) input_fifo (
      .clk         (axi_aclk),
      .reset       (!axi_resetn),
      .din         ({s_axis_tlast, tuser_mod, s_axis_tstrb, s_axis_tdata}),
      .wr_en       (xfer),
      .rd_en       (fifo_rd_en),
      .dout        ({m_axis_tlast, m_axis_tuser, m_axis_tstrb, m_axis_tdata}),
      .full        (),
      .nearly_full (fifo_nearly_full),
      .empty       (fifo_empty)
   );

   // Read ahead on ready, valid follows one clock later
   assign fifo_rd_en = m_axis_tready && !fifo_empty;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         m_axis_tvalid <= 1'b0;
      end else begin
         m_axis_tvalid <= fifo_rd_en;
      end
   end

endmodule

/* rtl/output_queues.sv */
// Per-destination packet queues fed from the lookup, draining to the MAC and CPU egress ports
`timescale 1ns/1ps

module output_queues #(
   parameter int C_AXIS_DATA_WIDTH = 64,
   parameter int C_USER_WIDTH      = 128,
   parameter int DST_PORT_POS      = 24,
   parameter int QUEUE_DEPTH_BITS  = 4
) (
   input  logic                           axi_aclk,
   input  logic                           axi_resetn,
   // From the lookup, valid one clock after ready
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s_axis_tuser,
   input  logic                           s_axis_tvalid,
   output logic                           s_axis_tready,
   input  logic                           s_axis_tlast,
   // Physical egress
   output logic [C_AXIS_DATA_WIDTH-1:0]   m0_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m0_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m0_axis_tuser,
   output logic                           m0_axis_tvalid,
   input  logic                           m0_axis_tready,
   output logic                           m0_axis_tlast,
   // CPU egress
   output logic [C_AXIS_DATA_WIDTH-1:0]   m1_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m1_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m1_axis_tuser,
   output logic                           m1_axis_tvalid,
   input  logic                           m1_axis_tready,
   output logic                           m1_axis_tlast
);

   localparam int beat_w = C_AXIS_DATA_WIDTH + C_AXIS_DATA_WIDTH / 8 + C_USER_WIDTH + 1;

   logic                                  in_pkt;
   logic                                  sel_q;
   logic                                  cur_sel;
   logic                                  next_is_header;
   logic [switch_pkg::port_byte_w-1:0]    dst_byte;
   logic [beat_w-1:0]                     q_dout [2];
   logic [1:0]                            q_nearly_full;
   logic [1:0]                            q_empty;
   logic [1:0]                            q_rd_en;
   logic [1:0]                            q_tready;
   logic [1:0]                            q_tvalid;

   //////////////////////////////
   // Demux on destination
   //////////////////////////////

   assign dst_byte = s_axis_tuser[DST_PORT_POS +: switch_pkg::port_byte_w];

   // Header picks from its own byte, later beats use the latch
   assign cur_sel = in_pkt ? sel_q : dst_byte[1];

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_pkt <= 1'b0;
         sel_q  <= 1'b0;
      end else if (s_axis_tvalid) begin
         in_pkt <= !s_axis_tlast;
         if (!in_pkt) begin
            sel_q <= dst_byte[1];
         end
      end
   end

   // Beat after this one may start a packet for either queue
   assign next_is_header = s_axis_tvalid ? s_axis_tlast : !in_pkt;
   assign s_axis_tready  = next_is_header ? !(|q_nearly_full) : !q_nearly_full[cur_sel];

   //////////////////////////////
   // Queues and egress
   //////////////////////////////

   assign q_tready = {m1_axis_tready, m0_axis_tready};

   for (genvar i = 0; i < 2; i++) begin : g_queue
      small_fifo #(
         .WIDTH          (beat_w),
         .MAX_DEPTH_BITS (QUEUE_DEPTH_BITS)
      ) out_fifo (
         .clk         (axi_aclk),
         .reset       (!axi_resetn),
         .din         ({s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata}),
         .wr_en       (s_axis_tvalid && (cur_sel == 1'(i))),
         .rd_en       (q_rd_en[i]),
         .dout        (q_dout[i]),
         .full        (),
         .nearly_full (q_nearly_full[i]),
         .empty       (q_empty[i])
      );

      // Each port drains under its own ready
      assign q_rd_en[i] = q_tready[i] && !q_empty[i];

      always_ff @(posedge axi_aclk) begin
         if (!axi_resetn) begin
            q_tvalid[i] <= 1'b0;
         end else begin
            q_tvalid[i] <= q_rd_en[i];
         end
      end
   end

   assign {m0_axis_tlast, m0_axis_tuser, m0_axis_tstrb, m0_axis_tdata} = q_dout[0];
   assign {m1_axis_tlast, m1_axis_tuser, m1_axis_tstrb, m1_axis_tdata} = q_dout[1];
   assign m0_axis_tvalid = q_tvalid[0];
   assign m1_axis_tvalid = q_tvalid[1];

endmodule

/* rtl/switch_datapath.sv */
// Top level of the two-port switch, arbiter into lookup into output queues
`timescale 1ns/1ps

module switch_datapath #(
   parameter int C_AXIS_DATA_WIDTH = switch_pkg::axis_data_width_default,
   parameter int C_USER_WIDTH      = switch_pkg::axis_user_width_default,
   parameter int QUEUE_DEPTH_BITS  = switch_pkg::fifo_depth_bits_default + 2
) (
   input  logic                           axi_aclk,
   input  logic                           axi_resetn,
   // MAC ingress
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s0_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s0_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s0_axis_tuser,
   input  logic                           s0_axis_tvalid,
   output logic                           s0_axis_tready,
   input  logic                           s0_axis_tlast,
   // CPU DMA ingress
   input  logic [C_AXIS_DATA_WIDTH-1:0]   s1_axis_tdata,
   input  logic [C_AXIS_DATA_WIDTH/8-1:0] s1_axis_tstrb,
   input  logic [C_USER_WIDTH-1:0]        s1_axis_tuser,
   input  logic                           s1_axis_tvalid,
   output logic                           s1_axis_tready,
   input  logic                           s1_axis_tlast,
   // MAC egress
   output logic [C_AXIS_DATA_WIDTH-1:0]   m0_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m0_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m0_axis_tuser,
   output logic                           m0_axis_tvalid,
   input  logic                           m0_axis_tready,
   output logic                           m0_axis_tlast,
   // CPU egress
   output logic [C_AXIS_DATA_WIDTH-1:0]   m1_axis_tdata,
   output logic [C_AXIS_DATA_WIDTH/8-1:0] m1_axis_tstrb,
   output logic [C_USER_WIDTH-1:0]        m1_axis_tuser,
   output logic                           m1_axis_tvalid,
   input  logic                           m1_axis_tready,
   output logic                           m1_axis_tlast
);

   //////////////////////////////
   // Internal streams
   //////////////////////////////

   // Arbiter to lookup
   logic [C_AXIS_DATA_WIDTH-1:0]   arb_axis_tdata;
   logic [C_AXIS_DATA_WIDTH/8-1:0] arb_axis_tstrb;
   logic [C_USER_WIDTH-1:0]        arb_axis_tuser;
   logic                           arb_axis_tvalid;
   logic                           arb_axis_tready;
   logic                           arb_axis_tlast;

   // Lookup to queues
   logic [C_AXIS_DATA_WIDTH-1:0]   opl_axis_tdata;
   logic [C_AXIS_DATA_WIDTH/8-1:0] opl_axis_tstrb;
   logic [C_USER_WIDTH-1:0]        opl_axis_tuser;
   logic                           opl_axis_tvalid;
   logic                           opl_axis_tready;
   logic                           opl_axis_tlast;

   input_arbiter #(
      .C_AXIS_DATA_WIDTH (C_AXIS_DATA_WIDTH),
      .C_USER_WIDTH      (C_USER_WIDTH)
   ) u_input_arbiter (
      .axi_aclk,
      .axi_resetn,
      .s0_axis_tdata,
      .s0_axis_tstrb,
      .s0_axis_tuser,
      .s0_axis_tvalid,
      .s0_axis_tready,
      .s0_axis_tlast,
      .s1_axis_tdata,
      .s1_axis_tstrb,
      .s1_axis_tuser,
      .s1_axis_tvalid,
      .s1_axis_tready,
      .s1_axis_tlast,
      .m_axis_tdata  (arb_axis_tdata),
      .m_axis_tstrb  (arb_axis_tstrb),
      .m_axis_tuser  (arb_axis_tuser),
      .m_axis_tvalid (arb_axis_tvalid),
      .m_axis_tready (arb_axis_tready),
      .m_axis_tlast  (arb_axis_tlast)
   );

   output_port_lookup #(
      .C_AXIS_DATA_WIDTH (C_AXIS_DATA_WIDTH),
      .C_USER_WIDTH      (C_USER_WIDTH),
      .SRC_PORT_POS      (switch_pkg::src_port_pos),
      .DST_PORT_POS      (switch_pkg::dst_port_pos)
   ) u_output_port_lookup (
      .axi_aclk,
      .axi_resetn,
      .m_axis_tdata  (opl_axis_tdata),
      .m_axis_tstrb  (opl_axis_tstrb),
      .m_axis_tuser  (opl_axis_tuser),
      .m_axis_tvalid (opl_axis_tvalid),
      .m_axis_tready (opl_axis_tready),
      .m_axis_tlast  (opl_axis_tlast),
      .s_axis_tdata  (arb_axis_tdata),
      .s_axis_tstrb  (arb_axis_tstrb),
      .s_axis_tuser  (arb_axis_tuser),
      .s_axis_tvalid (arb_axis_tvalid),
      .s_axis_tready (arb_axis_tready),
      .s_axis_tlast  (arb_axis_tlast)
   );

   // Deeper buffering at the egress side
   output_queues #(
      .C_AXIS_DATA_WIDTH (C_AXIS_DATA_WIDTH),
      .C_USER_WIDTH      (C_USER_WIDTH),
      .DST_PORT_POS      (switch_pkg::dst_port_pos),
      .QUEUE_DEPTH_BITS  (QUEUE_DEPTH_BITS)
   ) u_output_queues (
      .axi_aclk,
      .axi_resetn,
      .s_axis_tdata  (opl_axis_tdata),
      .s_axis_tstrb  (opl_axis_tstrb),
      .s_axis_tuser  (opl_axis_tuser),
      .s_axis_tvalid (opl_axis_tvalid),
      .s_axis_tready (opl_axis_tready),
      .s_axis_tlast  (opl_axis_tlast),
      .m0_axis_tdata,
      .m0_axis_tstrb,
      .m0_axis_tuser,
      .m0_axis_tvalid,
      .m0_axis_tready,
      .m0_axis_tlast,
      .m1_axis_tdata,
      .m1_axis_tstrb,
      .m1_axis_tuser,
      .m1_axis_tvalid,
      .m1_axis_tready,
      .m1_axis_tlast
   );

endmodule

/* verification/tb_switch_model.svh */
// Switch testbench model, included inside the testbench module for LFSR, expected queues, checks
`ifndef tb_switch_model_svh
`define tb_switch_model_svh

// One beat in the DUT's field order
typedef struct packed {
   logic          last;
   logic [uw-1:0] user;
   logic [sw-1:0] strb;
   logic [dw-1:0] data;
} beat_t;

// Expected beats, indexed by egress port
beat_t       exp_q [2][$];
int          error_count = 0;
int          beats_out   = 0;
logic [31:0] lfsr_state  = 32'h232e_d36f;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
   logic [31:0] bits;
   logic        fb;
   bits = '0;
   for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
   end
   return bits;
endfunction

// Port bytes as they leave the switch
function automatic logic [uw-1:0] expected_user(input int port, input logic [uw-1:0] user,
                                                input bit first);
   logic [uw-1:0] u;
   u = user;
   // MAC input is physical 0, DMA input is CPU 0
   u[switch_pkg::src_port_pos +: 8] = (port == 0) ? 8'h01 : 8'h02;
   // Header only, sent to the partner port
   if (first) begin
      u[switch_pkg::dst_port_pos +: 8] = (port == 0) ? 8'h02 : 8'h01;
   end
   return u;
endfunction

task automatic check_data(input string sig, input logic [dw-1:0] want, input logic [dw-1:0] got);
   if (got !== want) begin
      $display("Error %s expected %h got %h", sig, want, got);
      error_count++;
   end
endtask

task automatic check_strb(input string sig, input logic [sw-1:0] want, input logic [sw-1:0] got);
   if (got !== want) begin
      $display("Error %s expected %h got %h", sig, want, got);
      error_count++;
   end
endtask

task automatic check_user(input string sig, input logic [uw-1:0] want, input logic [uw-1:0] got);
   if (got !== want) begin
      $display("Error %s expected %h got %h", sig, want, got);
      error_count++;
   end
endtask

task automatic check_last(input string sig, input logic want, input logic got);
   if (got !== want) begin
      $display("Error %s expected %h got %h", sig, want, got);
      error_count++;
   end
endtask

// Egress beat against the head of its port's queue
task automatic compare_beat(input int port, input beat_t got);
   beat_t want;
   string prefix;
   prefix = $sformatf("m%0d_axis_", port);
   beats_out++;
   if (exp_q[port].size() == 0) begin
      $display("Unexpected beat on m%0d while no packet was pending for it", port);
      error_count++;
   end else begin
      want = exp_q[port].pop_front();
      check_data({prefix, "tdata"}, want.data, got.data);
      check_strb({prefix, "tstrb"}, want.strb, got.strb);
      check_user({prefix, "tuser"}, want.user, got.user);
      check_last({prefix, "tlast"}, want.last, got.last);
   end
endtask

`endif

/* verification/tb_switch_datapath.sv */
// Testbench for the switch datapath, random two-port traffic checked against a beat model
`timescale 1ns/1ps

module tb_switch_datapath;

   localparam int dw        = switch_pkg::axis_data_width_default;
   localparam int uw        = switch_pkg::axis_user_width_default;
   localparam int sw        = dw / 8;
   // Long m0 stall in the back-pressure test
   localparam int stall_len = 150;

   logic          axi_aclk;
   logic          axi_resetn;
   logic [dw-1:0] s0_axis_tdata;
   logic [sw-1:0] s0_axis_tstrb;
   logic [uw-1:0] s0_axis_tuser;
   logic          s0_axis_tvalid;
   logic          s0_axis_tready;
   logic          s0_axis_tlast;
   logic [dw-1:0] s1_axis_tdata;
   logic [sw-1:0] s1_axis_tstrb;
   logic [uw-1:0] s1_axis_tuser;
   logic          s1_axis_tvalid;
   logic          s1_axis_tready;
   logic          s1_axis_tlast;
   logic [dw-1:0] m0_axis_tdata;
   logic [sw-1:0] m0_axis_tstrb;
   logic [uw-1:0] m0_axis_tuser;
   logic          m0_axis_tvalid;
   logic          m0_axis_tready;
   logic          m0_axis_tlast;
   logic [dw-1:0] m1_axis_tdata;
   logic [sw-1:0] m1_axis_tstrb;
   logic [uw-1:0] m1_axis_tuser;
   logic          m1_axis_tvalid;
   logic          m1_axis_tready;
   logic          m1_axis_tlast;

   `include "tb_switch_model.svh"

   // Ingress beats waiting to be offered on each input
   beat_t stim_q [2][$];
   logic  cur_valid [2];
   logic  accepted [2];
   int    gap [2];
   int    injected_beats;
   int    cycle_count;
   int    cycle_limit;
   int    m1_stall_beats;

   switch_datapath uut (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #5 axi_aclk = ~axi_aclk;
   end

   // Run limit grows with each batch of packets
   always @(posedge axi_aclk) begin
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, missing output of %0d beats on m0 and %0d on m1",
                  cycle_count, exp_q[0].size(), exp_q[1].size());
         $display("Test failed");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus and model
   //////////////////////////////

   // Random packets on one input with expected copies for the other side
   task automatic add_packets(input int port, input int count);
      beat_t beat;
      int    len;
      for (int p = 0; p < count; p++) begin
         len = int'(take_bits(3) % 6) + 1;
         for (int b = 0; b < len; b++) begin
            for (int k = 0; k < dw / 32; k++) begin
               beat.data[k*32 +: 32] = take_bits(32);
            end
            for (int k = 0; k < uw / 32; k++) begin
               beat.user[k*32 +: 32] = take_bits(32);
            end
            beat.strb = sw'(take_bits(sw));
            beat.last = (b == len - 1);
            stim_q[port].push_back(beat);
            // Each input lands on the opposite egress port
            beat.user = expected_user(port, beat.user, b == 0);
            exp_q[1 - port].push_back(beat);
         end
         injected_beats += len;
         cycle_limit    += 40 * len;
      end
   endtask

   function automatic bit traffic_pending();
      return stim_q[0].size() != 0 || stim_q[1].size() != 0 ||
             exp_q[0].size() != 0 || exp_q[1].size() != 0;
   endfunction

   // Monitors, ingress drivers and egress ready for one falling edge
   task automatic step_cycle(input bit pressure, input bit stall_m0);
      // Egress beats held from the last rising edge
      if (m0_axis_tvalid) begin
         compare_beat(0, {m0_axis_tlast, m0_axis_tuser, m0_axis_tstrb, m0_axis_tdata});
      end
      if (m1_axis_tvalid) begin
         compare_beat(1, {m1_axis_tlast, m1_axis_tuser, m1_axis_tstrb, m1_axis_tdata});
         if (stall_m0) begin
            m1_stall_beats++;
         end
      end
      for (int p = 0; p < 2; p++) begin
         // Beat taken at the last rising edge
         if (accepted[p]) begin
            void'(stim_q[p].pop_front());
            cur_valid[p] = 1'b0;
            gap[p]       = take_bits(1) ? int'(take_bits(2)) : 0;
         end
         if (!cur_valid[p] && stim_q[p].size() != 0) begin
            if (gap[p] > 0) begin
               gap[p]--;
            end else begin
               cur_valid[p] = 1'b1;
            end
         end
      end
      s0_axis_tvalid = cur_valid[0];
      if (cur_valid[0]) begin
         {s0_axis_tlast, s0_axis_tuser, s0_axis_tstrb, s0_axis_tdata} = stim_q[0][0];
      end
      s1_axis_tvalid = cur_valid[1];
      if (cur_valid[1]) begin
         {s1_axis_tlast, s1_axis_tuser, s1_axis_tstrb, s1_axis_tdata} = stim_q[1][0];
      end
      // Ingress ready comes from registers and holds to the next rising edge
      accepted[0] = cur_valid[0] && s0_axis_tready;
      accepted[1] = cur_valid[1] && s1_axis_tready;
      if (pressure) begin
         m0_axis_tready = !stall_m0 && (take_bits(2) != 0);
         m1_axis_tready = (take_bits(2) != 0);
      end else begin
         m0_axis_tready = 1'b1;
         m1_axis_tready = 1'b1;
      end
      cycle_count++;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   // Run until both model queues drain and a few idle cycles pass
   task automatic run_test(input string name, input bit pressure);
      int start_errors;
      int start_out;
      int test_cycles;
      int idle;
      start_errors   = error_count;
      start_out      = beats_out;
      test_cycles    = 0;
      idle           = 0;
      m1_stall_beats = 0;
      while (idle < 10) begin
         @(negedge axi_aclk);
         step_cycle(pressure, pressure && (test_cycles < stall_len));
         test_cycles++;
         idle = traffic_pending() ? 0 : idle + 1;
      end
      if (pressure && m1_stall_beats == 0) begin
         $display("m1 delivered no beat while m0 was stalled");
         error_count++;
      end
      $display("%s: %0d beats out, %0d errors", name, beats_out - start_out,
               error_count - start_errors);
   endtask

   initial begin
      axi_resetn     = 1'b0;
      s0_axis_tdata  = '0;
      s0_axis_tstrb  = '0;
      s0_axis_tuser  = '0;
      s0_axis_tvalid = 1'b0;
      s0_axis_tlast  = 1'b0;
      s1_axis_tdata  = '0;
      s1_axis_tstrb  = '0;
      s1_axis_tuser  = '0;
      s1_axis_tvalid = 1'b0;
      s1_axis_tlast  = 1'b0;
      m0_axis_tready = 1'b1;
      m1_axis_tready = 1'b1;
      cur_valid      = '{1'b0, 1'b0};
      accepted       = '{1'b0, 1'b0};
      gap            = '{0, 0};
      injected_beats = 0;
      cycle_count    = 0;
      cycle_limit    = 200;
      // Four rising edges in reset
      repeat (4) @(negedge axi_aclk);
      axi_resetn = 1'b1;

      add_packets(0, 8);
      run_test("routing and header rewrite from s0 to m1", 1'b0);
      add_packets(1, 8);
      run_test("routing and header rewrite from s1 to m0", 1'b0);
      add_packets(0, 20);
      add_packets(1, 20);
      run_test("interleaved ingress", 1'b0);
      add_packets(0, 30);
      add_packets(1, 30);
      run_test("back-pressure with long m0 stall", 1'b1);

      $display("Summary: %0d beats in, %0d beats out, %0d errors", injected_beats, beats_out,
               error_count);
      if (error_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* switch_datapath.f */
+incdir+verification
rtl/switch_pkg.sv
rtl/small_fifo.sv
rtl/input_arbiter.sv
rtl/output_port_lookup.sv
rtl/output_queues.sv
rtl/switch_datapath.sv
verification/tb_switch_datapath.sv

/* Bender.yml */
package:
  name: switch_datapath

sources:
  # Design, package first
  - rtl/switch_pkg.sv
  - rtl/small_fifo.sv
  - rtl/input_arbiter.sv
  - rtl/output_port_lookup.sv
  - rtl/output_queues.sv
  - rtl/switch_datapath.sv
  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_switch_datapath.sv
